/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define XLEN       32
`define AREG_W     5
`define NUM_PHYS   64
`define PREG_W     6
`define ROB_DEPTH  8
`define ROB_W      3
`define MUL_STAGES 3

// major opcodes
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011

`define F7_MUL     7'b0000001

// funct3 of the supported ALU ops
`define F3_ADD     3'b000
`define F3_SLL     3'b001
`define F3_XOR     3'b100
`define F3_SRL     3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111

`endif

/* core_pkg.sv */
`include "core_params.svh"

package core_pkg;

    // one instruction word, two ways to read it
    typedef union packed {
        struct packed {
            logic [6:0]         funct7;
            logic [`AREG_W-1:0] rs2;
            logic [`AREG_W-1:0] rs1;
            logic [2:0]         funct3;
            logic [`AREG_W-1:0] rd;
            logic [6:0]         opcode;
        } r;
        struct packed {
            logic [11:0]        imm12;
            logic [`AREG_W-1:0] rs1;
            logic [2:0]         funct3;
            logic [`AREG_W-1:0] rd;
            logic [6:0]         opcode;
        } i;
    } insn_t;

endpackage

/* core_if.sv */
`timescale 1ns/1ns
`include "core_params.svh"

// tagged writeback from one execution unit
interface result_bus_if;
    logic               valid;
    logic [`PREG_W-1:0] tag;
    logic [`ROB_W-1:0]  rob_idx;
    logic [`XLEN-1:0]   value;

    modport source (output valid, tag, rob_idx, value);
    modport sink   (input  valid, tag, rob_idx, value);
endinterface

// issue queue to execution unit
interface issue_if;
    logic               valid;
    logic [3:0]         op;      // {funct7[5], funct3}
    logic [`XLEN-1:0]   a;
    logic [`XLEN-1:0]   b;
    logic [`PREG_W-1:0] dest;
    logic [`ROB_W-1:0]  rob_idx;
    logic               has_dest;

    modport source (output valid, op, a, b, dest, rob_idx, has_dest);
    modport sink   (input  valid, op, a, b, dest, rob_idx, has_dest);
endinterface

/* rename_unit.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module rename_unit
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               insn_valid,
    input  insn_t              insn,
    input  logic [`ROB_W-1:0]  rob_tail,
    output logic               disp_valid,
    output logic               disp_is_mul,
    output logic [3:0]         disp_op,
    output logic [`PREG_W-1:0] disp_tag_a,
    output logic [`PREG_W-1:0] disp_tag_b,
    output logic [`XLEN-1:0]   disp_imm,
    output logic               disp_use_imm,
    output logic [`PREG_W-1:0] disp_dest_tag,
    output logic               disp_has_dest,
    output logic [`PREG_W-1:0] disp_old_tag,
    output logic [`AREG_W-1:0] disp_rd,
    output logic [`ROB_W-1:0]  disp_rob_idx,
    input  logic               commit_free_valid,
    input  logic [`PREG_W-1:0] commit_free_tag
);
    localparam int NUM_AREG = 2 ** `AREG_W;
    localparam int FL_DEPTH = `NUM_PHYS - NUM_AREG;
    localparam int FL_W     = $clog2(FL_DEPTH);

    logic [`PREG_W-1:0] rat [NUM_AREG];
    logic [`PREG_W-1:0] free_list [FL_DEPTH];
    logic [FL_W-1:0]    fl_head;
    logic [FL_W-1:0]    fl_tail;
    logic               is_r;

    assign is_r          = insn.r.opcode == `OPC_OP;
    assign disp_valid    = insn_valid;
    assign disp_is_mul   = is_r && insn.r.funct7 == `F7_MUL;
    assign disp_op       = {is_r & insn.r.funct7[5], insn.i.funct3}; // no sub form for imm ops
    assign disp_use_imm  = insn.i.opcode == `OPC_OP_IMM;
    assign disp_imm      = {{(`XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};
    assign disp_tag_a    = rat[insn.i.rs1];
    assign disp_tag_b    = rat[insn.r.rs2];
    assign disp_rd       = insn.i.rd;
    assign disp_has_dest = insn_valid && insn.i.rd != '0;  // x0 keeps phys 0
    assign disp_dest_tag = free_list[fl_head];
    assign disp_old_tag  = rat[insn.i.rd];
    assign disp_rob_idx  = rob_tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AREG; i++) begin
                rat[i] <= `PREG_W'(i);
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= `PREG_W'(i + NUM_AREG);
            end
            fl_head <= '0;
            fl_tail <= '0;  // list starts full
        end else begin
            if (disp_has_dest) begin
                rat[insn.i.rd] <= free_list[fl_head];
                fl_head        <= fl_head + 1'b1;
            end
            if (commit_free_valid) begin
                free_list[fl_tail] <= commit_free_tag;
                fl_tail            <= fl_tail + 1'b1;
            end
        end
    end

endmodule

/* phys_reg_file.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module phys_reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`PREG_W-1:0] rd_tag_a,
    input  logic [`PREG_W-1:0] rd_tag_b,
    output logic [`XLEN-1:0]   rd_data_a,
    output logic [`XLEN-1:0]   rd_data_b,
    output logic               rd_valid_a,
    output logic               rd_valid_b,
    result_bus_if.sink         alu_res,
    result_bus_if.sink         mul_res,
    input  logic               alloc_valid,
    input  logic [`PREG_W-1:0] alloc_tag
);
    logic [`XLEN-1:0]    regs [`NUM_PHYS];
    logic [`NUM_PHYS-1:0] valid;

    // tag 0 stays x0 and is never written
    function automatic logic [`XLEN:0] lookup(input logic [`PREG_W-1:0] t);
        if (alu_res.valid && alu_res.tag == t && t != '0)
            return {1'b1, alu_res.value};
        if (mul_res.valid && mul_res.tag == t && t != '0)
            return {1'b1, mul_res.value};
        return {valid[t], regs[t]};
    endfunction

    always_comb begin
        {rd_valid_a, rd_data_a} = lookup(rd_tag_a);
        {rd_valid_b, rd_data_b} = lookup(rd_tag_b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_PHYS; i++) begin
                regs[i] <= '0;
            end
            valid <= {{(`NUM_PHYS-32){1'b0}}, {32{1'b1}}};  // initial map of x0..x31
        end else begin
            if (alloc_valid)
                valid[alloc_tag] <= 1'b0;
            if (alu_res.valid && alu_res.tag != '0) begin
                regs[alu_res.tag]  <= alu_res.value;
                valid[alu_res.tag] <= 1'b1;
            end
            if (mul_res.valid && mul_res.tag != '0) begin
                regs[mul_res.tag]  <= mul_res.value;
                valid[mul_res.tag] <= 1'b1;
            end
        end
    end

endmodule

/* issue_queue.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module issue_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               disp_valid,
    input  logic               disp_is_mul,
    input  logic [3:0]         disp_op,
    input  logic [`PREG_W-1:0] disp_tag_a,
    input  logic [`PREG_W-1:0] disp_tag_b,
    input  logic [`XLEN-1:0]   disp_imm,
    input  logic               disp_use_imm,
    input  logic [`PREG_W-1:0] disp_dest_tag,
    input  logic               disp_has_dest,
    input  logic [`ROB_W-1:0]  disp_rob_idx,
    input  logic [`XLEN-1:0]   rd_data_a,
    input  logic [`XLEN-1:0]   rd_data_b,
    input  logic               rd_valid_a,
    input  logic               rd_valid_b,
    result_bus_if.sink         alu_res,
    result_bus_if.sink         mul_res,
    issue_if.source            alu_iss,
    issue_if.source            mul_iss
);
    localparam int N = `ROB_DEPTH;

    logic [N-1:0]       q_valid;
    logic [N-1:0]       q_mul;
    logic [N-1:0]       q_rdy_a;
    logic [N-1:0]       q_rdy_b;
    logic [N-1:0]       q_has_dest;
    logic [3:0]         q_op [N];
    logic [`PREG_W-1:0] q_tag_a [N];
    logic [`PREG_W-1:0] q_tag_b [N];
    logic [`PREG_W-1:0] q_dest [N];
    logic [`XLEN-1:0]   q_val_a [N];
    logic [`XLEN-1:0]   q_val_b [N];
    logic [`ROB_W-1:0]  q_rob [N];
    logic [`ROB_W:0]    q_seq [N];
    logic [`ROB_W:0]    seq_cnt;   // dispatch order, one extra bit for wrap
    logic [`ROB_W-1:0]  free_idx;
    logic [`ROB_W-1:0]  alu_sel;
    logic [`ROB_W-1:0]  mul_sel;
    logic               alu_found;
    logic               mul_found;

    function automatic logic older(input logic [`ROB_W:0] x, input logic [`ROB_W:0] y);
        logic [`ROB_W:0] d;
        d = x - y;
        return d[`ROB_W];
    endfunction

    always_comb begin
        free_idx  = '0;
        alu_sel   = '0;
        mul_sel   = '0;
        alu_found = 1'b0;
        mul_found = 1'b0;
        for (int i = N - 1; i >= 0; i--) begin
            if (!q_valid[i])
                free_idx = i[`ROB_W-1:0];
        end
        for (int i = 0; i < N; i++) begin
            if (q_valid[i] && q_rdy_a[i] && q_rdy_b[i]) begin
                if (!q_mul[i] && (!alu_found || older(q_seq[i], q_seq[alu_sel]))) begin
                    alu_found = 1'b1;
                    alu_sel   = i[`ROB_W-1:0];
                end
                if (q_mul[i] && (!mul_found || older(q_seq[i], q_seq[mul_sel]))) begin
                    mul_found = 1'b1;
                    mul_sel   = i[`ROB_W-1:0];
                end
            end
        end
    end

    assign alu_iss.valid    = alu_found;
    assign alu_iss.op       = q_op[alu_sel];
    assign alu_iss.a        = q_val_a[alu_sel];
    assign alu_iss.b        = q_val_b[alu_sel];
    assign alu_iss.dest     = q_dest[alu_sel];
    assign alu_iss.rob_idx  = q_rob[alu_sel];
    assign alu_iss.has_dest = q_has_dest[alu_sel];

    assign mul_iss.valid    = mul_found;
    assign mul_iss.op       = q_op[mul_sel];
    assign mul_iss.a        = q_val_a[mul_sel];
    assign mul_iss.b        = q_val_b[mul_sel];
    assign mul_iss.dest     = q_dest[mul_sel];
    assign mul_iss.rob_idx  = q_rob[mul_sel];
    assign mul_iss.has_dest = q_has_dest[mul_sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= '0;
            seq_cnt <= '0;
        end else begin
            if (alu_found)
                q_valid[alu_sel] <= 1'b0;
            if (mul_found)
                q_valid[mul_sel] <= 1'b0;
            if (disp_valid) begin
                q_valid[free_idx] <= 1'b1;
                seq_cnt           <= seq_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin  // wakeup
            if (!q_rdy_a[i] && alu_res.valid && alu_res.tag == q_tag_a[i]) begin
                q_val_a[i] <= alu_res.value;
                q_rdy_a[i] <= 1'b1;
            end
            if (!q_rdy_a[i] && mul_res.valid && mul_res.tag == q_tag_a[i]) begin
                q_val_a[i] <= mul_res.value;
                q_rdy_a[i] <= 1'b1;
            end
            if (!q_rdy_b[i] && alu_res.valid && alu_res.tag == q_tag_b[i]) begin
                q_val_b[i] <= alu_res.value;
                q_rdy_b[i] <= 1'b1;
            end
            if (!q_rdy_b[i] && mul_res.valid && mul_res.tag == q_tag_b[i]) begin
                q_val_b[i] <= mul_res.value;
                q_rdy_b[i] <= 1'b1;
            end
        end
        if (disp_valid) begin
            q_mul[free_idx]      <= disp_is_mul;
            q_op[free_idx]       <= disp_op;
            q_tag_a[free_idx]    <= disp_tag_a;
            q_tag_b[free_idx]    <= disp_tag_b;
            q_dest[free_idx]     <= disp_dest_tag;
            q_has_dest[free_idx] <= disp_has_dest;
            q_rob[free_idx]      <= disp_rob_idx;
            q_seq[free_idx]      <= seq_cnt;
            q_rdy_a[free_idx]    <= disp_tag_a == '0 || rd_valid_a;
            q_val_a[free_idx]    <= (disp_tag_a == '0) ? '0 : rd_data_a;  // x0 reads zero
            q_rdy_b[free_idx]    <= disp_use_imm || disp_tag_b == '0 || rd_valid_b;
            if (disp_use_imm)
                q_val_b[free_idx] <= disp_imm;
            else
                q_val_b[free_idx] <= (disp_tag_b == '0) ? '0 : rd_data_b;
        end
    end

endmodule

/* alu_unit.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module alu_unit (
    input logic          clk,
    input logic          rst_n,
    issue_if.sink        alu_iss,
    result_bus_if.source alu_res
);
    logic [`XLEN-1:0] result;

    always_comb begin
        case (alu_iss.op[2:0])
            `F3_ADD: result = alu_iss.op[3] ? alu_iss.a - alu_iss.b : alu_iss.a + alu_iss.b;
            `F3_SLL: result = alu_iss.a << alu_iss.b[4:0];
            `F3_XOR: result = alu_iss.a ^ alu_iss.b;
            `F3_SRL: result = alu_iss.a >> alu_iss.b[4:0];
            `F3_OR:  result = alu_iss.a | alu_iss.b;
            `F3_AND: result = alu_iss.a & alu_iss.b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            alu_res.valid <= 1'b0;
        else
            alu_res.valid <= alu_iss.valid;
    end

    always_ff @(posedge clk) begin
        alu_res.value   <= result;
        alu_res.rob_idx <= alu_iss.rob_idx;
        alu_res.tag     <= alu_iss.has_dest ? alu_iss.dest : '0;  // x0 writes go to tag 0
    end

endmodule

/* mul_unit.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module mul_unit (
    input logic          clk,
    input logic          rst_n,
    issue_if.sink        mul_iss,
    result_bus_if.source mul_res
);
    localparam int S = `MUL_STAGES;
    localparam int H = `XLEN / 2;

    logic [S-1:0]       st_valid;
    logic [`PREG_W-1:0] st_tag [S];
    logic [`ROB_W-1:0]  st_rob [S];
    logic [`XLEN-1:0]   pp_lo;
    logic [`XLEN-1:0]   pp_hl;
    logic [`XLEN-1:0]   pp_lh;
    logic [`XLEN-1:0]   st_prod [1:S-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= '0;
        end else begin
            st_valid[0] <= mul_iss.valid;
            for (int k = 1; k < S; k++) begin
                st_valid[k] <= st_valid[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        // stage 0: half-word partial products, only the low word is kept
        pp_lo     <= mul_iss.a[H-1:0] * mul_iss.b[H-1:0];
        pp_hl     <= mul_iss.a[`XLEN-1:H] * mul_iss.b[H-1:0];
        pp_lh     <= mul_iss.a[H-1:0] * mul_iss.b[`XLEN-1:H];
        st_tag[0] <= mul_iss.has_dest ? mul_iss.dest : '0;
        st_rob[0] <= mul_iss.rob_idx;
        st_prod[1] <= pp_lo + ((pp_hl + pp_lh) << H);
        for (int k = 1; k < S; k++) begin
            st_tag[k] <= st_tag[k-1];
            st_rob[k] <= st_rob[k-1];
        end
        for (int k = 2; k < S; k++) begin
            st_prod[k] <= st_prod[k-1];
        end
    end

    assign mul_res.valid   = st_valid[S-1];
    assign mul_res.tag     = st_tag[S-1];
    assign mul_res.rob_idx = st_rob[S-1];
    assign mul_res.value   = st_prod[S-1];

endmodule

/* reorder_buffer.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc_valid,
    input  logic [`AREG_W-1:0] alloc_rd,
    input  logic [`PREG_W-1:0] alloc_old_tag,
    input  logic               alloc_has_dest,
    output logic [`ROB_W-1:0]  rob_tail,
    result_bus_if.sink         alu_res,
    result_bus_if.sink         mul_res,
    output logic               commit_valid,
    output logic [`AREG_W-1:0] commit_rd,
    output logic [`XLEN-1:0]   commit_value,
    output logic               free_valid,
    output logic [`PREG_W-1:0] free_tag
);
    logic [`ROB_DEPTH-1:0] e_valid;
    logic [`ROB_DEPTH-1:0] e_done;
    logic [`ROB_DEPTH-1:0] e_has_dest;
    logic [`AREG_W-1:0]    e_rd [`ROB_DEPTH];
    logic [`PREG_W-1:0]    e_old [`ROB_DEPTH];
    logic [`XLEN-1:0]      e_value [`ROB_DEPTH];
    logic [`ROB_W-1:0]     head;
    logic [`ROB_W-1:0]     tail;

    assign rob_tail     = tail;
    assign commit_valid = e_valid[head] & e_done[head];
    assign commit_rd    = e_rd[head];
    assign commit_value = e_value[head];
    assign free_valid   = commit_valid & e_has_dest[head];  // old mapping now dead
    assign free_tag     = e_old[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_valid <= '0;
            e_done  <= '0;
            head    <= '0;
            tail    <= '0;
        end else begin
            if (alloc_valid) begin
                e_valid[tail] <= 1'b1;
                e_done[tail]  <= 1'b0;
                tail          <= tail + 1'b1;
            end
            if (alu_res.valid)
                e_done[alu_res.rob_idx] <= 1'b1;
            if (mul_res.valid)
                e_done[mul_res.rob_idx] <= 1'b1;
            if (commit_valid) begin
                e_valid[head] <= 1'b0;
                head          <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            e_rd[tail]       <= alloc_rd;
            e_old[tail]      <= alloc_old_tag;
            e_has_dest[tail] <= alloc_has_dest;
        end
        if (alu_res.valid)
            e_value[alu_res.rob_idx] <= alu_res.value;
        if (mul_res.valid)
            e_value[mul_res.rob_idx] <= mul_res.value;
    end

endmodule

/* ooo_core.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module ooo_core
    import core_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               insn_valid,
    input  insn_t              insn,
    output logic               commit_valid,
    output logic [`AREG_W-1:0] commit_rd,
    output logic [`XLEN-1:0]   commit_value
);
    logic               disp_valid;
    logic               disp_is_mul;
    logic [3:0]         disp_op;
    logic [`PREG_W-1:0] disp_tag_a;
    logic [`PREG_W-1:0] disp_tag_b;
    logic [`XLEN-1:0]   disp_imm;
    logic               disp_use_imm;
    logic [`PREG_W-1:0] disp_dest_tag;
    logic               disp_has_dest;
    logic [`PREG_W-1:0] disp_old_tag;
    logic [`AREG_W-1:0] disp_rd;
    logic [`ROB_W-1:0]  disp_rob_idx;
    logic [`ROB_W-1:0]  rob_tail;
    logic [`XLEN-1:0]   rd_data_a;
    logic [`XLEN-1:0]   rd_data_b;
    logic               rd_valid_a;
    logic               rd_valid_b;
    logic               free_valid;
    logic [`PREG_W-1:0] free_tag;

    result_bus_if alu_res ();
    result_bus_if mul_res ();
    issue_if      alu_iss ();
    issue_if      mul_iss ();

    rename_unit u_rename (
        .clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn), .rob_tail(rob_tail),
        .disp_valid(disp_valid), .disp_is_mul(disp_is_mul), .disp_op(disp_op),
        .disp_tag_a(disp_tag_a), .disp_tag_b(disp_tag_b), .disp_imm(disp_imm),
        .disp_use_imm(disp_use_imm), .disp_dest_tag(disp_dest_tag),
        .disp_has_dest(disp_has_dest), .disp_old_tag(disp_old_tag), .disp_rd(disp_rd),
        .disp_rob_idx(disp_rob_idx),
        .commit_free_valid(free_valid), .commit_free_tag(free_tag)
    );

    phys_reg_file u_prf (
        .clk(clk), .rst_n(rst_n), .rd_tag_a(disp_tag_a), .rd_tag_b(disp_tag_b),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_valid_a(rd_valid_a), .rd_valid_b(rd_valid_b),
        .alu_res(alu_res), .mul_res(mul_res),
        .alloc_valid(disp_has_dest), .alloc_tag(disp_dest_tag)
    );

    issue_queue u_iq (
        .clk(clk), .rst_n(rst_n), .disp_valid(disp_valid), .disp_is_mul(disp_is_mul),
        .disp_op(disp_op), .disp_tag_a(disp_tag_a), .disp_tag_b(disp_tag_b),
        .disp_imm(disp_imm), .disp_use_imm(disp_use_imm), .disp_dest_tag(disp_dest_tag),
        .disp_has_dest(disp_has_dest), .disp_rob_idx(disp_rob_idx),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .rd_valid_a(rd_valid_a), .rd_valid_b(rd_valid_b),
        .alu_res(alu_res), .mul_res(mul_res), .alu_iss(alu_iss), .mul_iss(mul_iss)
    );

    alu_unit u_alu (.clk(clk), .rst_n(rst_n), .alu_iss(alu_iss), .alu_res(alu_res));

    mul_unit u_mul (.clk(clk), .rst_n(rst_n), .mul_iss(mul_iss), .mul_res(mul_res));

    reorder_buffer u_rob (
        .clk(clk), .rst_n(rst_n), .alloc_valid(disp_valid), .alloc_rd(disp_rd),
        .alloc_old_tag(disp_old_tag), .alloc_has_dest(disp_has_dest), .rob_tail(rob_tail),
        .alu_res(alu_res), .mul_res(mul_res),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value),
        .free_valid(free_valid), .free_tag(free_tag)
    );

endmodule

/* ooo_core_props.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module ooo_core_props (
    input logic               clk,
    input logic               rst_n,
    input logic               commit_valid,
    input logic [`AREG_W-1:0] commit_rd,
    input logic               alu_valid,
    input logic [`PREG_W-1:0] alu_tag,
    input logic               mul_valid,
    input logic [`PREG_W-1:0] mul_tag
);
    commit_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !commit_valid)
        else $error("commit_valid high during reset");

    commit_rd_known: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> !$isunknown(commit_rd))
        else $error("commit_rd unknown on a commit");

    // tag 0 is the x0 sink, both units may target it at once
    result_tags_differ: assert property (@(posedge clk) disable iff (!rst_n)
        alu_valid && mul_valid && alu_tag != '0 |-> alu_tag != mul_tag)
        else $error("both result buses carry tag %0d", alu_tag);
endmodule

bind ooo_core ooo_core_props u_props (
    .clk(clk), .rst_n(rst_n), .commit_valid(commit_valid), .commit_rd(commit_rd),
    .alu_valid(alu_res.valid), .alu_tag(alu_res.tag),
    .mul_valid(mul_res.valid), .mul_tag(mul_res.tag)
);

/* ooo_core_tb.sv */
`timescale 1ns/1ns
`include "core_params.svh"

module ooo_core_tb
    import core_pkg::*;
();
    localparam int NUM_DIRECTED   = 25;
    localparam int NUM_RANDOM     = 400;
    localparam int TIMEOUT_CYCLES = 12 * (NUM_DIRECTED + NUM_RANDOM) + 200;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               insn_valid;
    insn_t              insn;
    logic               commit_valid;
    logic [`AREG_W-1:0] commit_rd;
    logic [`XLEN-1:0]   commit_value;

    logic [`XLEN-1:0]   model_regs [32];
    logic [`AREG_W-1:0] exp_rd [$];
    logic [`XLEN-1:0]   exp_val [$];
    string              exp_test [$];
    string              test_name;
    int                 sent = 0;
    int                 commit_count = 0;
    int                 cycles = 0;

    ooo_core uut (
        .clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn),
        .commit_valid(commit_valid), .commit_rd(commit_rd), .commit_value(commit_value)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] expected,
                               input logic [`XLEN-1:0] actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch in %s value: expected %h, actual %h",
                               name, expected, actual));
    endtask

    task automatic check_rd(input string name, input logic [`AREG_W-1:0] expected,
                            input logic [`AREG_W-1:0] actual);
        if (actual !== expected)
            fail_run($sformatf("mismatch in %s rd: expected %0d, actual %0d",
                               name, expected, actual));
    endtask

    function automatic insn_t rtype_word(input logic [6:0] f7, input logic [`AREG_W-1:0] rs2,
                                         input logic [`AREG_W-1:0] rs1, input logic [2:0] f3,
                                         input logic [`AREG_W-1:0] rd);
        insn_t w;
        w.r = {f7, rs2, rs1, f3, rd, `OPC_OP};
        return w;
    endfunction

    function automatic insn_t itype_word(input logic [11:0] imm, input logic [`AREG_W-1:0] rs1,
                                         input logic [2:0] f3, input logic [`AREG_W-1:0] rd);
        insn_t w;
        w.i = {imm, rs1, f3, rd, `OPC_OP_IMM};
        return w;
    endfunction

    // architectural model in program order
    function automatic void model_exec(input insn_t ins);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] v;
        logic             is_r;
        is_r = ins.r.opcode == `OPC_OP;
        a    = model_regs[ins.r.rs1];
        b    = is_r ? model_regs[ins.r.rs2] : {{(`XLEN-12){ins.i.imm12[11]}}, ins.i.imm12};
        case (ins.r.funct3)
            `F3_ADD: v = (is_r && ins.r.funct7[5]) ? a - b : a + b;
            `F3_SLL: v = a << b[4:0];
            `F3_XOR: v = a ^ b;
            `F3_SRL: v = a >> b[4:0];
            `F3_OR:  v = a | b;
            default: v = a & b;
        endcase
        if (is_r && ins.r.funct7 == `F7_MUL)
            v = a * b;  // low word only
        exp_rd.push_back(ins.r.rd);
        exp_val.push_back(v);
        exp_test.push_back(test_name);
        if (ins.r.rd != '0)
            model_regs[ins.r.rd] = v;
    endfunction

    function automatic insn_t random_insn();
        logic [`AREG_W-1:0] rd;
        logic [`AREG_W-1:0] rs1;
        logic [`AREG_W-1:0] rs2;
        logic [11:0]        imm;
        rd  = `AREG_W'($urandom_range(0, 15));
        rs1 = `AREG_W'($urandom_range(0, 15));
        rs2 = `AREG_W'($urandom_range(0, 15));
        imm = 12'($urandom);
        case ($urandom_range(0, 13))
            0:  return rtype_word(7'b0000000, rs2, rs1, `F3_ADD, rd);
            1:  return rtype_word(7'b0100000, rs2, rs1, `F3_ADD, rd);
            2:  return rtype_word(7'b0000000, rs2, rs1, `F3_AND, rd);
            3:  return rtype_word(7'b0000000, rs2, rs1, `F3_OR, rd);
            4:  return rtype_word(7'b0000000, rs2, rs1, `F3_XOR, rd);
            5:  return rtype_word(7'b0000000, rs2, rs1, `F3_SLL, rd);
            6:  return rtype_word(7'b0000000, rs2, rs1, `F3_SRL, rd);
            7:  return rtype_word(`F7_MUL, rs2, rs1, `F3_ADD, rd);
            8:  return itype_word(imm, rs1, `F3_ADD, rd);
            9:  return itype_word(imm, rs1, `F3_AND, rd);
            10: return itype_word(imm, rs1, `F3_OR, rd);
            11: return itype_word(imm, rs1, `F3_XOR, rd);
            12: return itype_word({7'b0, imm[4:0]}, rs1, `F3_SLL, rd);
            default: return itype_word({7'b0, imm[4:0]}, rs1, `F3_SRL, rd);
        endcase
    endfunction

    // called on a falling edge
    // holds off while the reorder buffer is full
    task automatic send_insn(input insn_t ins);
        while (sent - commit_count >= `ROB_DEPTH) begin
            insn_valid = 1'b0;
            @(negedge clk);
        end
        insn       = ins;
        insn_valid = 1'b1;
        model_exec(ins);
        sent++;
        @(negedge clk);
        insn_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
            fail_run("timeout, commits stopped arriving before every instruction committed");
        if (commit_valid && !rst_n)
            fail_run("commit_valid went high during reset");
        if (commit_valid && rst_n) begin
            if (exp_rd.size() == 0)
                fail_run("a commit arrived with no instruction outstanding");
            check_rd(exp_test[0], exp_rd[0], commit_rd);
            check_value(exp_test[0], exp_val[0], commit_value);
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
            void'(exp_test.pop_front());
            commit_count++;
        end
    end

    initial begin
        rst_n      = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        test_name  = "reset";
        void'($urandom(32'h2b4039dc));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        test_name = "first_addi";
        send_insn(itype_word(12'hffb, 5'd0, `F3_ADD, 5'd1));  // addi x1, x0, -5

        test_name = "dep_chain";
        send_insn(itype_word(12'd100, 5'd1, `F3_ADD, 5'd2));
        send_insn(rtype_word(7'b0000000, 5'd1, 5'd2, `F3_ADD, 5'd3));
        send_insn(rtype_word(7'b0100000, 5'd2, 5'd3, `F3_ADD, 5'd4));  // sub
        send_insn(itype_word(12'h7ff, 5'd4, `F3_XOR, 5'd5));
        send_insn(rtype_word(7'b0000000, 5'd1, 5'd5, `F3_SLL, 5'd6));
        send_insn(rtype_word(7'b0000000, 5'd2, 5'd6, `F3_SRL, 5'd7));
        send_insn(rtype_word(7'b0000000, 5'd3, 5'd7, `F3_OR, 5'd8));
        send_insn(itype_word(12'h0f0, 5'd8, `F3_AND, 5'd9));
        send_insn(itype_word(12'd4, 5'd9, `F3_SLL, 5'd10));
        send_insn(itype_word(12'd2, 5'd10, `F3_SRL, 5'd11));

        test_name = "mul_order";
        send_insn(itype_word(12'd1234, 5'd0, `F3_ADD, 5'd12));
        send_insn(itype_word(12'hfb3, 5'd0, `F3_ADD, 5'd13));  // -77
        send_insn(rtype_word(`F7_MUL, 5'd13, 5'd12, `F3_ADD, 5'd14));
        send_insn(rtype_word(`F7_MUL, 5'd3, 5'd14, `F3_ADD, 5'd15));
        send_insn(itype_word(12'd5, 5'd0, `F3_ADD, 5'd16));
        send_insn(rtype_word(7'b0000000, 5'd2, 5'd1, `F3_XOR, 5'd17));
        send_insn(rtype_word(7'b0000000, 5'd16, 5'd16, `F3_ADD, 5'd18));
        send_insn(itype_word(12'd3, 5'd1, `F3_SRL, 5'd19));

        test_name = "x0_write";
        send_insn(itype_word(12'd55, 5'd1, `F3_ADD, 5'd0));
        send_insn(rtype_word(7'b0000000, 5'd3, 5'd2, `F3_ADD, 5'd0));
        send_insn(rtype_word(`F7_MUL, 5'd13, 5'd12, `F3_ADD, 5'd0));
        send_insn(rtype_word(7'b0000000, 5'd0, 5'd0, `F3_ADD, 5'd20));
        send_insn(itype_word(12'd9, 5'd0, `F3_ADD, 5'd21));
        send_insn(rtype_word(7'b0000000, 5'd1, 5'd0, `F3_OR, 5'd22));

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_insn(random_insn());
            if ($urandom_range(0, 7) == 0)
                @(negedge clk);  // occasional bubble
        end

        while (commit_count < sent) @(negedge clk);
        repeat (20) @(negedge clk);  // quiet window for stray commits
        $display("All tests passed");
        $finish;
    end

endmodule

/* ooo_core.f */
+incdir+.
core_pkg.sv
core_if.sv
rename_unit.sv
phys_reg_file.sv
issue_queue.sv
alu_unit.sv
mul_unit.sv
reorder_buffer.sv
ooo_core.sv
ooo_core_props.sv
ooo_core_tb.sv

/* Makefile */
TOP = ooo_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ooo_core.f -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
